// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 of register and immediate arithmetic
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 of branches and jalr
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam logic [31:0] INST_ECALL = 32'h0000_0073;

    typedef enum logic [3:0] {
        op_alu_reg,
        op_alu_imm,
        op_lui,
        op_branch,
        op_jal,
        op_jalr,
        op_ecall,
        op_illegal
    } op_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef enum logic [1:0] {
        br_eq,
        br_ne,
        br_lt
    } br_cond_e;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      run_i,
    input  logic                      redirect_i,
    input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
    output logic                      imem_req_o,
    output logic [core_pkg::XLEN-1:0] imem_addr_o
);
    import core_pkg::*;

    // pc is the address of the request on the port this cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            imem_req_o  <= 1'b0;
            imem_addr_o <= RESET_PC;
        end else begin
            imem_req_o <= run_i;
            if (redirect_i) begin
                imem_addr_o <= redirect_pc_i;
            end else if (imem_req_o) begin
                imem_addr_o <= imem_addr_o + XLEN'(4);
            end
        end
    end

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]                     inst_i,
    output core_pkg::op_e                   op_o,
    output core_pkg::alu_op_e               alu_op_o,
    output core_pkg::br_cond_e              br_cond_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [core_pkg::XLEN-1:0]       imm_o
);
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    alu_op_e         f3_alu;
    logic            f3_ok;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // shared by register and immediate arithmetic
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD: f3_alu = alu_add;
            F3_SLT: f3_alu = alu_slt;
            F3_XOR: f3_alu = alu_xor;
            F3_OR:  f3_alu = alu_or;
            F3_AND: f3_alu = alu_and;
            default: begin
                f3_alu = alu_add;
                f3_ok  = 1'b0;
            end
        endcase
    end

    always_comb begin
        op_o      = op_illegal;
        alu_op_o  = f3_alu;
        br_cond_o = br_eq;
        imm_o     = imm_i;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    op_o     = op_alu_reg;
                    alu_op_o = alu_sub;
                end else if (funct7 == F7_BASE && f3_ok) begin
                    op_o = op_alu_reg;
                end
            end
            OPC_OP_IMM: begin
                if (f3_ok) begin
                    op_o = op_alu_imm;
                end
            end
            OPC_LUI: begin
                op_o  = op_lui;
                imm_o = imm_u;
            end
            OPC_BRANCH: begin
                imm_o = imm_b;
                op_o  = op_branch;
                case (funct3)
                    F3_BEQ:  br_cond_o = br_eq;
                    F3_BNE:  br_cond_o = br_ne;
                    F3_BLT:  br_cond_o = br_lt;
                    default: op_o = op_illegal;
                endcase
            end
            OPC_JAL: begin
                op_o  = op_jal;
                imm_o = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    op_o = op_jalr;
                end
            end
            OPC_SYSTEM: begin
                if (inst_i == INST_ECALL) begin
                    op_o = op_ecall;
                end
            end
            default: op_o = op_illegal;
        endcase
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);
    import core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we_i && waddr_i == addr) begin
            // write-through from write-back
            value = wdata_i;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = read_port(rs1_i);
    assign rdata2_o = read_port(rs2_i);

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_unit (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            dec_valid_i,
    input  logic [core_pkg::XLEN-1:0]       pc_i,
    input  core_pkg::op_e                   op_i,
    input  core_pkg::alu_op_e               alu_op_i,
    input  core_pkg::br_cond_e              br_cond_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [core_pkg::XLEN-1:0]       imm_i,
    input  logic [core_pkg::XLEN-1:0]       rdata1_i,
    input  logic [core_pkg::XLEN-1:0]       rdata2_i,
    input  logic                            flush_i,
    output logic                            taken_o,
    output logic [core_pkg::XLEN-1:0]       target_o,
    output logic                            ex_ecall_o,
    output logic                            wb_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [core_pkg::XLEN-1:0]       wb_data_o,
    output logic                            wb_ecall_o
);
    import core_pkg::*;

    logic                  ex_valid;
    logic [XLEN-1:0]       ex_pc;
    op_e                   ex_op;
    alu_op_e               ex_alu_op;
    br_cond_e              ex_br_cond;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_imm;
    logic [XLEN-1:0]       ex_src1;
    logic [XLEN-1:0]       ex_src2;

    logic                  ex_wen;
    logic                  br_hit;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       ex_result;
    logic [XLEN-1:0]       fwd1;
    logic [XLEN-1:0]       fwd2;

    assign ex_wen = ex_valid && ex_rd != '0 &&
                    ex_op inside {op_alu_reg, op_alu_imm, op_lui, op_jal, op_jalr};

    // execute result bypasses the register read of the next instruction
    assign fwd1 = (ex_wen && ex_rd == rs1_i) ? ex_result : rdata1_i;
    assign fwd2 = (ex_wen && ex_rd == rs2_i) ? ex_result : rdata2_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= pc_i;
        ex_op      <= op_i;
        ex_alu_op  <= alu_op_i;
        ex_br_cond <= br_cond_i;
        ex_rd      <= rd_i;
        ex_imm     <= imm_i;
        ex_src1    <= fwd1;
        ex_src2    <= fwd2;
    end

    assign alu_b = (ex_op == op_alu_reg) ? ex_src2 : ex_imm;

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_res = ex_src1 - alu_b;
            alu_and: alu_res = ex_src1 & alu_b;
            alu_or:  alu_res = ex_src1 | alu_b;
            alu_xor: alu_res = ex_src1 ^ alu_b;
            alu_slt: alu_res = XLEN'($signed(ex_src1) < $signed(alu_b));
            default: alu_res = ex_src1 + alu_b;
        endcase
    end

    always_comb begin
        case (ex_op)
            op_lui:          ex_result = ex_imm;
            op_jal, op_jalr: ex_result = ex_pc + XLEN'(4);
            default:         ex_result = alu_res;
        endcase
    end

    always_comb begin
        case (ex_br_cond)
            br_ne:   br_hit = ex_src1 != ex_src2;
            br_lt:   br_hit = $signed(ex_src1) < $signed(ex_src2);
            default: br_hit = ex_src1 == ex_src2;
        endcase
    end

    assign taken_o = ex_valid &&
                     (ex_op == op_jal || ex_op == op_jalr || (ex_op == op_branch && br_hit));
    assign target_o = (ex_op == op_jalr) ? ((ex_src1 + ex_imm) & ~XLEN'(1)) : ex_pc + ex_imm;
    assign ex_ecall_o = ex_valid && ex_op == op_ecall;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_ecall_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_wen;
            wb_ecall_o <= ex_ecall_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= ex_rd;
        wb_data_o <= ex_result;
    end

    // both fetches behind a redirect must be dropped before execute
    assert property (@(posedge clk) disable iff (rst_i)
        taken_o |=> !ex_valid ##1 !ex_valid);

    // only killed responses may carry unknown encodings
    assert property (@(posedge clk) disable iff (rst_i)
        dec_valid_i && !flush_i |-> op_i != op_illegal);

endmodule

`default_nettype wire

// ==== pipeline_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module pipeline_ctrl (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      req_i,
    input  logic [core_pkg::XLEN-1:0] req_pc_i,
    input  logic                      imem_rsp_i,
    input  logic                      taken_i,
    input  logic                      ex_ecall_i,
    input  logic                      wb_ecall_i,
    output logic [core_pkg::XLEN-1:0] rsp_pc_o,
    output logic                      dec_valid_o,
    output logic                      flush_o,
    output logic                      run_o,
    output logic                      exit_o
);

    logic taken_q;
    logic halt_q;
    logic exit_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            taken_q <= 1'b0;
            halt_q  <= 1'b0;
            exit_q  <= 1'b0;
        end else begin
            taken_q <= taken_i;
            if (ex_ecall_i) begin
                halt_q <= 1'b1;
            end
            if (wb_ecall_i) begin
                exit_q <= 1'b1;
            end
        end
    end

    // pc of the response arriving next cycle
    always_ff @(posedge clk) begin
        rsp_pc_o <= req_pc_i;
    end

    // response in decode is younger than the redirecting instruction
    assign flush_o = taken_i || ex_ecall_i;

    // taken_q kills the fetch issued in the redirect cycle
    assign dec_valid_o = imem_rsp_i && !taken_q && !halt_q;

    assign run_o  = !halt_q && !ex_ecall_i;
    assign exit_o = exit_q || wb_ecall_i;

    assert property (@(posedge clk) disable iff (rst_i) req_i |=> imem_rsp_i);
    assert property (@(posedge clk) disable iff (rst_i) imem_rsp_i |-> $past(req_i));

endmodule

`default_nettype wire

// ==== rv_core_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module rv_core_top (
    input  logic                            clk,
    input  logic                            rst_i,
    output logic                            imem_req_o,
    output logic [core_pkg::XLEN-1:0]       imem_addr_o,
    input  logic                            imem_rsp_i,
    input  logic [31:0]                     imem_inst_i,
    output logic                            ret_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0] ret_rd_o,
    output logic [core_pkg::XLEN-1:0]       ret_data_o,
    output logic                            exit_o
);
    import core_pkg::*;

    logic                  run;
    logic                  taken;
    logic [XLEN-1:0]       target;
    logic [XLEN-1:0]       rsp_pc;
    logic                  dec_valid;
    logic                  flush;
    op_e                   dec_op;
    alu_op_e               dec_alu_op;
    br_cond_e              dec_br_cond;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [XLEN-1:0]       dec_imm;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic                  ex_ecall;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  wb_ecall;

    assign ret_valid_o = wb_valid;
    assign ret_rd_o    = wb_rd;
    assign ret_data_o  = wb_data;

    fetch_unit i_fetch_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .run_i         (run),
        .redirect_i    (taken),
        .redirect_pc_i (target),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o)
    );

    pipeline_ctrl i_pipeline_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (imem_req_o),
        .req_pc_i    (imem_addr_o),
        .imem_rsp_i  (imem_rsp_i),
        .taken_i     (taken),
        .ex_ecall_i  (ex_ecall),
        .wb_ecall_i  (wb_ecall),
        .rsp_pc_o    (rsp_pc),
        .dec_valid_o (dec_valid),
        .flush_o     (flush),
        .run_o       (run),
        .exit_o      (exit_o)
    );

    inst_decoder i_inst_decoder (
        .inst_i    (imem_inst_i),
        .op_o      (dec_op),
        .alu_op_o  (dec_alu_op),
        .br_cond_o (dec_br_cond),
        .rd_o      (dec_rd),
        .rs1_o     (dec_rs1),
        .rs2_o     (dec_rs2),
        .imm_o     (dec_imm)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rs1_i    (dec_rs1),
        .rs2_i    (dec_rs2),
        .we_i     (wb_valid),
        .waddr_i  (wb_rd),
        .wdata_i  (wb_data),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    execute_unit i_execute_unit (
        .clk         (clk),
        .rst_i       (rst_i),
        .dec_valid_i (dec_valid),
        .pc_i        (rsp_pc),
        .op_i        (dec_op),
        .alu_op_i    (dec_alu_op),
        .br_cond_i   (dec_br_cond),
        .rd_i        (dec_rd),
        .rs1_i       (dec_rs1),
        .rs2_i       (dec_rs2),
        .imm_i       (dec_imm),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .flush_i     (flush),
        .taken_o     (taken),
        .target_o    (target),
        .ex_ecall_o  (ex_ecall),
        .wb_valid_o  (wb_valid),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data),
        .wb_ecall_o  (wb_ecall)
    );

endmodule

`default_nettype wire

// ==== tb_isa.svh ====
`ifndef TB_ISA_SVH
`define TB_ISA_SVH

// rv32i major opcodes and funct3 values
localparam logic [6:0] OP_REG    = 7'b0110011;
localparam logic [6:0] OP_IMM    = 7'b0010011;
localparam logic [6:0] OP_LUI    = 7'b0110111;
localparam logic [6:0] OP_BRANCH = 7'b1100011;
localparam logic [6:0] OP_JAL    = 7'b1101111;
localparam logic [6:0] OP_JALR   = 7'b1100111;
localparam logic [31:0] ECALL_INST = 32'h0000_0073;

localparam logic [2:0] FN_ADD = 3'b000;
localparam logic [2:0] FN_SLT = 3'b010;
localparam logic [2:0] FN_XOR = 3'b100;
localparam logic [2:0] FN_OR  = 3'b110;
localparam logic [2:0] FN_AND = 3'b111;
localparam logic [2:0] BR_EQ  = 3'b000;
localparam logic [2:0] BR_NE  = 3'b001;
localparam logic [2:0] BR_LT  = 3'b100;

localparam logic [2:0] ALU_FUNCTS [5] = '{FN_ADD, FN_SLT, FN_XOR, FN_OR, FN_AND};

// expected retirements in program order
logic [4:0]  exp_rd_q [$];
logic [31:0] exp_data_q [$];

function automatic logic [31:0] alu_reg_inst(input logic is_sub, input logic [2:0] f3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {is_sub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] alu_imm_inst(input logic [2:0] f3, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_IMM};
endfunction

function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OP_LUI};
endfunction

function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

function automatic logic [31:0] jalr_inst(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_JALR};
endfunction

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic is_sub,
        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        FN_SLT:  return {31'b0, $signed(a) < $signed(b)};
        FN_XOR:  return a ^ b;
        FN_OR:   return a | b;
        FN_AND:  return a & b;
        default: return is_sub ? a - b : a + b;
    endcase
endfunction

// instruction-set model, runs prog_mem from address zero up to the ecall
task automatic run_model(output bit reached_ecall);
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        wr;
    bit          br;
    int          steps;
    for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    exp_rd_q.delete();
    exp_data_q.delete();
    pc = '0;
    steps = 0;
    reached_ecall = 1'b0;
    while (!reached_ecall && steps < 4000) begin
        inst = prog_mem[pc[9:2]];
        a = regs[inst[19:15]];
        b = regs[inst[24:20]];
        imm = {{20{inst[31]}}, inst[31:20]};
        next_pc = pc + 32'd4;
        wr = 1'b1;
        res = '0;
        case (inst[6:0])
            OP_REG: res = alu_model(inst[14:12], inst[30], a, b);
            OP_IMM: res = alu_model(inst[14:12], 1'b0, a, imm);
            OP_LUI: res = {inst[31:12], 12'b0};
            OP_BRANCH: begin
                wr = 1'b0;
                case (inst[14:12])
                    BR_EQ:   br = a == b;
                    BR_NE:   br = a != b;
                    default: br = $signed(a) < $signed(b);
                endcase
                if (br) begin
                    next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
                end
            end
            OP_JAL: begin
                res = pc + 32'd4;
                next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
            end
            OP_JALR: begin
                res = pc + 32'd4;
                next_pc = (a + imm) & ~32'd1;
            end
            default: begin
                wr = 1'b0;
                reached_ecall = (inst == ECALL_INST);
            end
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            regs[inst[11:7]] = res;
            exp_rd_q.push_back(inst[11:7]);
            exp_data_q.push_back(res);
        end
        pc = next_pc;
        steps++;
    end
endtask

`endif

// ==== tb_rv_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          MEM_WORDS = 256;
    localparam int          RUN_LIMIT = 2000;
    localparam logic [31:0] FIRST_PC  = 32'h0000_0000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_rsp = 1'b0;
    logic [31:0] imem_inst = '0;
    logic        ret_valid;
    logic [4:0]  ret_rd;
    logic [31:0] ret_data;
    logic        core_exit;

    logic [31:0] prog_mem [0:MEM_WORDS-1];
    int          prog_len;
    int          check_errors;
    int          seq_errors;
    int          retired;
    int          tests_run;
    int          tests_failed;
    logic [4:0]  head_rd;
    logic [31:0] head_data;

    `include "tb_isa.svh"

    rv_core_top i_rv_core_top (
        .clk         (clk),
        .rst_i       (rst),
        .imem_req_o  (imem_req),
        .imem_addr_o (imem_addr),
        .imem_rsp_i  (imem_rsp),
        .imem_inst_i (imem_inst),
        .ret_valid_o (ret_valid),
        .ret_rd_o    (ret_rd),
        .ret_data_o  (ret_data),
        .exit_o      (core_exit)
    );

    always #5 clk = ~clk;

    // program memory answers each request one cycle later
    always @(posedge clk) begin
        imem_rsp  <= imem_req;
        imem_inst <= prog_mem[imem_addr[9:2]];
    end

    always @(negedge clk) begin
        if (!rst && ret_valid) begin
            retired++;
            assert (ret_rd != 5'd0) else begin
                $display("error at %0t: ret_rd_o = %0d, expected nonzero", $time, ret_rd);
                check_errors++;
            end
            assert (exp_rd_q.size() > 0) else begin
                $display("retirement of x%0d at %0t that the model does not predict",
                         ret_rd, $time);
                check_errors++;
            end
            if (exp_rd_q.size() > 0) begin
                head_rd = exp_rd_q.pop_front();
                head_data = exp_data_q.pop_front();
                assert (ret_rd == head_rd) else begin
                    $display("error at %0t: ret_rd_o = %0d, expected %0d",
                             $time, ret_rd, head_rd);
                    check_errors++;
                end
                assert (ret_data == head_data) else begin
                    $display("error at %0t: ret_data_o = %h, expected %h",
                             $time, ret_data, head_data);
                    check_errors++;
                end
            end
        end
        // core stays quiet once it has exited
        if (!rst && core_exit) begin
            assert (!ret_valid && !imem_req) else begin
                $display("retirement or fetch after exit at %0t", $time);
                check_errors++;
            end
        end
    end

    task automatic clear_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            // addi x0 with the byte address, harmless when fetched and killed
            prog_mem[i] = alu_imm_inst(FN_ADD, 5'd0, 5'd0, 12'(i * 4));
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] inst);
        prog_mem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_test(input string name);
        bit model_ok;
        int errors_before;
        int retired_before;
        int cycles;
        errors_before = check_errors + seq_errors;
        retired_before = retired;
        run_model(model_ok);
        assert (model_ok) else begin
            $display("model did not reach the ecall in test %s", name);
            seq_errors++;
        end
        apply_reset();
        cycles = 0;
        @(negedge clk);
        while (!imem_req && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        assert (imem_req) else begin
            $display("no fetch request after reset in test %s", name);
            seq_errors++;
        end
        assert (imem_addr == FIRST_PC) else begin
            $display("error at %0t: imem_addr_o = %h, expected %h", $time, imem_addr, FIRST_PC);
            seq_errors++;
        end
        assert (!ret_valid && !core_exit && !imem_rsp) else begin
            $display("retirement or exit active before the first response in test %s", name);
            seq_errors++;
        end
        cycles = 0;
        while (!core_exit && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (core_exit) else begin
            $display("timeout, exit_o did not rise in test %s", name);
            seq_errors++;
        end
        // quiet period after exit, watched by the retirement checker
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
        end
        assert (exp_rd_q.size() == 0) else begin
            $display("error at %0t: expected queue size = %0d, expected 0",
                     $time, exp_rd_q.size());
            seq_errors++;
        end
        tests_run++;
        if (check_errors + seq_errors == errors_before) begin
            $display("test %s: ok, %0d retired", name, retired - retired_before);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, check_errors + seq_errors - errors_before);
        end
    endtask

    task automatic build_random_alu();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        clear_program();
        for (int r = 1; r < 8; r++) begin
            emit(alu_imm_inst(FN_ADD, 5'(r), 5'd0, 12'($urandom)));
        end
        // few registers, so dependencies come back to back
        for (int n = 0; n < 40; n++) begin
            kind = $urandom_range(2, 0);
            rd = 5'($urandom_range(7, 0));
            rs1 = 5'($urandom_range(7, 0));
            rs2 = 5'($urandom_range(7, 0));
            f3 = ALU_FUNCTS[$urandom_range(4, 0)];
            if (kind == 0) begin
                emit(alu_reg_inst(f3 == FN_ADD && $urandom_range(1, 0) == 1, f3, rd, rs1, rs2));
            end else if (kind == 1) begin
                emit(alu_imm_inst(f3, rd, rs1, 12'($urandom)));
            end else begin
                emit(lui_inst(rd, 20'($urandom)));
            end
        end
        emit(ECALL_INST);
    endtask

    task automatic build_branches();
        clear_program();
        emit(alu_imm_inst(FN_ADD, 5'd1, 5'd0, 12'd5));
        emit(alu_imm_inst(FN_ADD, 5'd2, 5'd0, 12'd5));
        emit(alu_imm_inst(FN_ADD, 5'd3, 5'd0, 12'(-3)));
        emit(branch_inst(BR_EQ, 5'd1, 5'd2, 13'd12));
        emit(alu_imm_inst(FN_ADD, 5'd4, 5'd0, 12'd1));
        emit(alu_imm_inst(FN_ADD, 5'd4, 5'd0, 12'd2));
        emit(branch_inst(BR_NE, 5'd1, 5'd2, 13'd8));
        emit(alu_imm_inst(FN_ADD, 5'd5, 5'd0, 12'd7));
        emit(branch_inst(BR_LT, 5'd3, 5'd1, 13'd12));
        emit(alu_imm_inst(FN_ADD, 5'd5, 5'd0, 12'd9));
        emit(alu_imm_inst(FN_ADD, 5'd6, 5'd0, 12'd9));
        emit(branch_inst(BR_LT, 5'd1, 5'd3, 13'd8));
        emit(branch_inst(BR_NE, 5'd1, 5'd3, 13'd12));
        emit(alu_imm_inst(FN_ADD, 5'd6, 5'd0, 12'd1));
        emit(alu_imm_inst(FN_ADD, 5'd6, 5'd0, 12'd2));
        emit(branch_inst(BR_EQ, 5'd1, 5'd3, 13'd8));
        emit(jal_inst(5'd7, 21'd12));
        emit(alu_imm_inst(FN_ADD, 5'd4, 5'd0, 12'd3));
        emit(alu_imm_inst(FN_ADD, 5'd4, 5'd0, 12'd4));
        emit(alu_imm_inst(FN_ADD, 5'd6, 5'd0, 12'd96));
        // odd target, bit 0 is dropped
        emit(jalr_inst(5'd5, 5'd6, 12'd1));
        emit(alu_imm_inst(FN_ADD, 5'd4, 5'd0, 12'd5));
        emit(alu_imm_inst(FN_ADD, 5'd4, 5'd0, 12'd6));
        emit(alu_imm_inst(FN_ADD, 5'd4, 5'd0, 12'd7));
        emit(alu_reg_inst(1'b0, FN_ADD, 5'd4, 5'd7, 5'd5));
        emit(ECALL_INST);
    endtask

    task automatic build_x0_program();
        clear_program();
        emit(alu_imm_inst(FN_ADD, 5'd1, 5'd0, 12'd77));
        emit(alu_imm_inst(FN_ADD, 5'd0, 5'd1, 12'd5));
        emit(lui_inst(5'd0, 20'habcde));
        emit(alu_reg_inst(1'b0, FN_ADD, 5'd2, 5'd0, 5'd1));
        emit(alu_imm_inst(FN_ADD, 5'd3, 5'd0, 12'(-1)));
        emit(alu_reg_inst(1'b0, FN_OR, 5'd0, 5'd3, 5'd1));
        emit(alu_reg_inst(1'b1, FN_ADD, 5'd4, 5'd0, 5'd3));
        emit(jal_inst(5'd0, 21'd8));
        emit(alu_imm_inst(FN_ADD, 5'd5, 5'd0, 12'd1));
        emit(alu_imm_inst(FN_XOR, 5'd5, 5'd0, 12'h055));
        emit(ECALL_INST);
    endtask

    task automatic build_loop_program();
        logic [11:0] count;
        count = 12'($urandom_range(8, 3));
        clear_program();
        emit(alu_imm_inst(FN_ADD, 5'd1, 5'd0, 12'd0));
        emit(alu_imm_inst(FN_ADD, 5'd2, 5'd0, count));
        emit(alu_reg_inst(1'b0, FN_ADD, 5'd1, 5'd1, 5'd2));
        emit(alu_imm_inst(FN_ADD, 5'd2, 5'd2, 12'(-1)));
        emit(branch_inst(BR_NE, 5'd2, 5'd0, 13'(-8)));
        emit(alu_imm_inst(FN_SLT, 5'd3, 5'd1, 12'd20));
        emit(ECALL_INST);
    endtask

    initial begin
        void'($urandom(32'hf02b4fe1));
        clear_program();
        emit(alu_imm_inst(FN_ADD, 5'd1, 5'd0, 12'd5));
        emit(ECALL_INST);
        run_test("reset and first fetch");
        build_random_alu();
        run_test("random alu sequence");
        build_branches();
        run_test("branches and jumps");
        build_x0_program();
        run_test("x0 writes and reads");
        build_loop_program();
        run_test("loop ending in ecall");
        $display("%0d tests, %0d failed, %0d retired, %0d errors",
                 tests_run, tests_failed, retired, check_errors + seq_errors);
        if (check_errors + seq_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
core_pkg.sv
fetch_unit.sv
inst_decoder.sv
reg_file.sv
execute_unit.sv
pipeline_ctrl.sv
rv_core_top.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
